// File: Bender.yml
package:
  name: frame_buffer

sources:
  - include_dirs:
      - design
    files:
      - design/fb_types_pkg.sv
      - design/fb_ctrl_pkg.sv
      - design/fb_mem_port_if.sv
      - design/fb_sync_fifo.sv
      - design/fb_wr_logic.sv
      - design/fb_rd_logic.sv
      - design/fb_mem_ctrl.sv
      - design/frame_buffer.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_frame_buffer.sv

// File: design/fb_config.svh
/* build-time sizes of the frame buffer; slot count and frame size are run-time inputs
   frame size must be a nonzero multiple of FB_BURST_LEN and fit in 2**FB_FRAME_WORDS_WIDTH */
`ifndef FB_CONFIG_SVH
`define FB_CONFIG_SVH

// ----------------------------------------
// data path
// ----------------------------------------
`define FB_DATA_WIDTH         32   // pixel bits
`define FB_PTR_WIDTH          2    // up to 4 slots
`define FB_FRAME_WORDS_WIDTH  10   // 1024 words per slot

// ----------------------------------------
// bursts and buffering
// ----------------------------------------
`define FB_BURST_LEN          16   // words per grant
`define FB_FRONT_DEPTH        64   // input side
`define FB_OUT_DEPTH          64   // output side, sets reader credits

`endif

// File: design/fb_ctrl_pkg.sv
/* state encodings of the write side, read side and memory arbiter */
package fb_ctrl_pkg;

	// input admission uses IDLE/FILL/DROP, burst side uses IDLE/BURST
	typedef enum logic [1:0] {WR_IDLE, WR_FILL, WR_DROP, WR_BURST} wr_state_t;

	typedef enum logic [1:0] {
		RD_IDLE,         // no frame in flight
		RD_WAIT_CREDIT,  // waiting for room in output fifo
		RD_BURST,        // request or beats running
		RD_RELEASE       // slot handed back
	} rd_state_t;

	typedef enum logic [1:0] {ARB_NONE, ARB_WRITER, ARB_READER} arb_owner_t;

endpackage

// File: design/fb_mem_ctrl.sv
/* round-robin judge over one single-port on-chip memory, one burst at a time
   at least one idle cycle between grants */
`timescale 1ns/1ps
`include "fb_config.svh"

module fb_mem_ctrl
	import fb_types_pkg::*;
	import fb_ctrl_pkg::*;
(
	input  logic           clk_frame_buf,
	input  logic           i_rst,
	fb_mem_port_if.arbiter wr_port,
	fb_mem_port_if.arbiter rd_port
);
	localparam int BW = $clog2(`FB_BURST_LEN);

	arb_owner_t owner, last_grant, pick;
	logic       ack_q, in_burst, rvalid_q;
	logic [BW-1:0] beat;
	mem_addr_t  base, beat_addr;
	pixel_t     rdata_q;
	pixel_t     ram [0:2**(`FB_PTR_WIDTH+`FB_FRAME_WORDS_WIDTH)-1];

	// ----------------------------------------
	// judge
	// ----------------------------------------
	always_comb begin
		pick = ARB_NONE;
		if (wr_port.req && rd_port.req)
			pick = (last_grant == ARB_WRITER) ? ARB_READER : ARB_WRITER; // alternate
		else if (wr_port.req)
			pick = ARB_WRITER;
		else if (rd_port.req)
			pick = ARB_READER;
	end

	always_ff @(posedge clk_frame_buf) begin
		if (i_rst) begin
			owner      <= ARB_NONE;
			last_grant <= ARB_READER; // writer wins first tie
			ack_q      <= 1'b0;
			in_burst   <= 1'b0;
			beat       <= '0;
			rvalid_q   <= 1'b0;
		end else begin
			ack_q    <= 1'b0;
			rvalid_q <= in_burst && (owner == ARB_READER);
			if (owner == ARB_NONE && pick != ARB_NONE) begin
				owner      <= pick;
				last_grant <= pick;
				ack_q      <= 1'b1;
			end
			if (ack_q) begin
				in_burst <= 1'b1; // beats start after the ack cycle
				beat     <= '0;
			end else if (in_burst) begin
				beat <= beat + 1'b1;
				if (beat == BW'(`FB_BURST_LEN - 1)) begin
					in_burst <= 1'b0;
					owner    <= ARB_NONE;
				end
			end
		end
	end

	// ----------------------------------------
	// memory
	// ----------------------------------------
	assign beat_addr = base + mem_addr_t'(beat);

	always_ff @(posedge clk_frame_buf) begin
		if (owner == ARB_NONE) base <= (pick == ARB_WRITER) ? wr_port.addr : rd_port.addr;
		if (in_burst && owner == ARB_WRITER && wr_port.wvalid)
			ram[beat_addr] <= wr_port.wdata;
		rdata_q <= ram[beat_addr]; // lands one cycle after its beat
	end

	assign wr_port.ack    = ack_q && (owner == ARB_WRITER);
	assign rd_port.ack    = ack_q && (owner == ARB_READER);
	assign wr_port.last   = in_burst && (owner == ARB_WRITER) && (beat == BW'(`FB_BURST_LEN - 1));
	assign rd_port.last   = in_burst && (owner == ARB_READER) && (beat == BW'(`FB_BURST_LEN - 1));
	assign wr_port.rdata  = rdata_q;
	assign wr_port.rvalid = 1'b0;
	assign rd_port.rdata  = rdata_q;
	assign rd_port.rvalid = rvalid_q;

	// grant goes to one port only, and only to a port still asking
	a_one_ack : assert property (@(posedge clk_frame_buf) disable iff (i_rst)
		(wr_port.ack || rd_port.ack) |->
			(wr_port.ack ? (wr_port.req && !rd_port.ack) : rd_port.req));
	a_no_ack_mid_burst : assert property (@(posedge clk_frame_buf) disable iff (i_rst)
		(wr_port.ack || rd_port.ack) |-> !in_burst);

endmodule

// File: design/fb_mem_port_if.sv
/* one burst channel into the memory arbiter; req and addr held until the ack pulse,
   then FB_BURST_LEN beats follow, last on the final one */
`timescale 1ns/1ps

interface fb_mem_port_if
	import fb_types_pkg::*;
();
	logic      req;     // burst wanted
	logic      ack;     // single cycle grant
	mem_addr_t addr;    // burst base
	pixel_t    wdata;
	logic      wvalid;  // write beat carries data
	pixel_t    rdata;
	logic      rvalid;  // one cycle behind its beat
	logic      last;    // final beat

	modport requester (output req, addr, wdata, wvalid, input ack, rdata, rvalid, last);
	modport arbiter   (input req, addr, wdata, wvalid, output ack, rdata, rvalid, last);

endinterface

// File: design/fb_rd_logic.sv
/* reads whole frames from the oldest slot; i_frame_size must be a nonzero multiple
   of FB_BURST_LEN, output word top bit marks pixel 0 of a frame */
`timescale 1ns/1ps
`include "fb_config.svh"

module fb_rd_logic
	import fb_types_pkg::*;
	import fb_ctrl_pkg::*;
(
	input  logic             clk_frame_buf,
	input  logic             i_rst,
	input  logic             i_frame_ready,
	input  frame_ptr_t       i_base_ptr,
	input  frame_words_t     i_frame_size,
	input  frame_ptr_t       i_frame_depth,
	input  logic             i_buf_rd,
	output logic             o_release,
	output logic             o_buf_empty,
	output logic             o_buf_pe,
	output out_word_t        o_image_dout,
	fb_mem_port_if.requester mem
);
	localparam int           CW    = $clog2(`FB_OUT_DEPTH) + 1;
	localparam frame_words_t BURST = frame_words_t'(`FB_BURST_LEN);

	rd_state_t    state;
	logic [CW-1:0] cred;    // free output fifo entries not yet claimed
	logic [CW-1:0] of_cnt;
	frame_words_t rd_off;   // next burst offset
	frame_words_t push_off; // words pushed this frame
	logic         pop;

	fb_sync_fifo #(.WIDTH(`FB_DATA_WIDTH + 1), .DEPTH(`FB_OUT_DEPTH)) u_out_fifo (
		.clk_frame_buf (clk_frame_buf),
		.i_rst         (i_rst),
		.i_wr_en       (mem.rvalid),
		.i_din         ({push_off == '0, mem.rdata}), // flag on offset 0
		.i_rd_en       (pop),
		.o_dout        (o_image_dout),
		.o_full        (),
		.o_empty       (o_buf_empty),
		.o_count       (of_cnt)
	);

	assign pop        = i_buf_rd && !o_buf_empty;
	assign o_buf_pe   = (of_cnt < CW'(`FB_BURST_LEN));
	assign o_release  = (state == RD_RELEASE);
	assign mem.addr   = {i_base_ptr, rd_off[`FB_FRAME_WORDS_WIDTH-1:0]};
	assign mem.wdata  = '0; // read only channel
	assign mem.wvalid = 1'b0;

	always_ff @(posedge clk_frame_buf) begin
		if (i_rst) begin
			state    <= RD_IDLE;
			mem.req  <= 1'b0;
			cred     <= CW'(`FB_OUT_DEPTH);
			rd_off   <= '0;
			push_off <= '0;
		end else begin
			// claim a whole burst at ack, give back per word drained
			cred <= cred - (mem.ack ? CW'(`FB_BURST_LEN) : '0) + CW'(pop);
			if (mem.rvalid) push_off <= push_off + 1'b1;
			case (state)
				RD_IDLE: if (i_frame_ready) begin
					state    <= RD_WAIT_CREDIT;
					rd_off   <= '0;
					push_off <= '0;
				end
				RD_WAIT_CREDIT: if (cred >= CW'(`FB_BURST_LEN)) begin
					mem.req <= 1'b1;
					state   <= RD_BURST;
				end
				RD_BURST: begin
					if (mem.ack) mem.req <= 1'b0;
					if (mem.last) begin
						rd_off <= rd_off + BURST;
						state  <= (rd_off + BURST >= i_frame_size) ? RD_RELEASE : RD_WAIT_CREDIT;
					end
				end
				default: state <= RD_IDLE; // release pulse, final word lands now
			endcase
		end
	end

	a_cred_bound : assert property (@(posedge clk_frame_buf) disable iff (i_rst)
		cred <= CW'(`FB_OUT_DEPTH));
	// writer's oldest slot stays inside the configured ring
	a_base_in_ring : assert property (@(posedge clk_frame_buf) disable iff (i_rst)
		i_frame_ready |-> i_base_ptr <= i_frame_depth);

endmodule

// File: design/fb_sync_fifo.sv
/* first-word-fall-through fifo, o_dout valid while o_empty is low
   caller must not write when full or read when empty */
`timescale 1ns/1ps

module fb_sync_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 64   // power of two
) (
	input  logic                     clk_frame_buf,
	input  logic                     i_rst,
	input  logic                     i_wr_en,
	input  logic [WIDTH-1:0]         i_din,
	input  logic                     i_rd_en,
	output logic [WIDTH-1:0]         o_dout,
	output logic                     o_full,
	output logic                     o_empty,
	output logic [$clog2(DEPTH):0]   o_count
);
	localparam int AW = $clog2(DEPTH);

	logic [WIDTH-1:0] mem [0:DEPTH-1]; // no reset, payload only
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic [AW:0]      count;

	always_ff @(posedge clk_frame_buf) begin
		if (i_wr_en)
			mem[wr_ptr] <= i_din;
	end

	always_ff @(posedge clk_frame_buf) begin
		if (i_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (i_wr_en) wr_ptr <= wr_ptr + 1'b1; // wraps at DEPTH
			if (i_rd_en) rd_ptr <= rd_ptr + 1'b1;
			count <= count + (AW+1)'(i_wr_en) - (AW+1)'(i_rd_en);
		end
	end

	assign o_dout  = mem[rd_ptr]; // fall through
	assign o_full  = (count == (AW+1)'(DEPTH));
	assign o_empty = (count == '0);
	assign o_count = count;

	a_no_overflow  : assert property (@(posedge clk_frame_buf) disable iff (i_rst) o_full |-> !i_wr_en);
	a_no_underflow : assert property (@(posedge clk_frame_buf) disable iff (i_rst) o_empty |-> !i_rd_en);

endmodule

// File: design/fb_types_pkg.sv
/* vector types shared by every frame buffer block */
`include "fb_config.svh"

package fb_types_pkg;

	typedef logic [`FB_DATA_WIDTH-1:0] pixel_t;          // one pixel word
	typedef logic [`FB_DATA_WIDTH:0]   out_word_t;       // top bit = frame start flag

	typedef logic [`FB_PTR_WIDTH-1:0]  frame_ptr_t;      // slot index

	// slot index on top, word offset below
	typedef logic [`FB_PTR_WIDTH+`FB_FRAME_WORDS_WIDTH-1:0] mem_addr_t;

	typedef logic [`FB_FRAME_WORDS_WIDTH:0] frame_words_t; // words in a frame, full count fits
	typedef logic [`FB_PTR_WIDTH:0]         slot_cnt_t;    // occupied slots, 0..4

endpackage

// File: design/fb_wr_logic.sv
/* a frame is dropped whole if no slot is free when fval rises; the upstream must honor
   o_front_fifo_full and only one finished frame may wait for its final flush */
`timescale 1ns/1ps
`include "fb_config.svh"

module fb_wr_logic
	import fb_types_pkg::*;
	import fb_ctrl_pkg::*;
(
	input  logic             clk_frame_buf,
	input  logic             i_rst,
	input  logic             i_fval,
	input  logic             i_dval,
	input  pixel_t           i_image_din,
	input  frame_ptr_t       i_frame_depth,   // slots minus one
	input  logic             i_release,       // reader done with oldest slot
	output logic             o_front_fifo_full,
	output logic             o_frame_ready,
	output frame_ptr_t       o_base_ptr,
	fb_mem_port_if.requester mem
);
	localparam frame_words_t BURST = frame_words_t'(`FB_BURST_LEN);

	wr_state_t    in_state, bst_state;
	logic         fval_q, admit;
	logic         fifo_wr, fifo_rd, fifo_empty;
	pixel_t       fifo_dout;
	logic [$clog2(`FB_FRONT_DEPTH):0] fifo_cnt;
	frame_words_t in_words, end_words, wr_off, bst_len, remain, avail;
	logic         pend_end;  // frame ended, words still in fifo
	logic         in_beats, commit, can_go;
	logic [$clog2(`FB_BURST_LEN):0] beat;
	frame_ptr_t   wr_ptr, base_ptr;
	slot_cnt_t    occ;

	function automatic frame_ptr_t ptr_next(frame_ptr_t p, frame_ptr_t d);
		return (p == d) ? '0 : p + 1'b1; // modulo depth+1
	endfunction

	fb_sync_fifo #(.WIDTH(`FB_DATA_WIDTH), .DEPTH(`FB_FRONT_DEPTH)) u_front_fifo (
		.clk_frame_buf (clk_frame_buf),
		.i_rst         (i_rst),
		.i_wr_en       (fifo_wr),
		.i_din         (i_image_din),
		.i_rd_en       (fifo_rd),
		.o_dout        (fifo_dout),
		.o_full        (o_front_fifo_full),
		.o_empty       (fifo_empty),
		.o_count       (fifo_cnt)
	);

	// ----------------------------------------
	// admission, pending frame takes a slot too
	// ----------------------------------------
	assign admit   = i_fval && !fval_q && (in_state == WR_IDLE) &&
	                 (occ + slot_cnt_t'(pend_end) <= {1'b0, i_frame_depth});
	assign fifo_wr = i_fval && i_dval && (admit || in_state == WR_FILL);

	always_ff @(posedge clk_frame_buf) begin
		if (i_rst) begin
			in_state  <= WR_IDLE;
			fval_q    <= 1'b0;
			pend_end  <= 1'b0;
			in_words  <= '0;
			end_words <= '0;
		end else begin
			fval_q <= i_fval;
			if (commit) pend_end <= 1'b0;
			case (in_state)
				WR_IDLE: begin
					in_words <= frame_words_t'(fifo_wr); // first pixel may ride the edge
					if (i_fval && !fval_q) in_state <= admit ? WR_FILL : WR_DROP;
				end
				WR_FILL: begin
					if (!i_fval) begin
						in_state <= WR_IDLE;
						if (in_words != '0) begin
							pend_end  <= 1'b1;
							end_words <= in_words;
						end
					end else if (fifo_wr) begin
						in_words <= in_words + 1'b1;
					end
				end
				WR_DROP: if (!i_fval) in_state <= WR_IDLE; // discard until fval falls
				default: in_state <= WR_IDLE;
			endcase
		end
	end

	// ----------------------------------------
	// burst side
	// ----------------------------------------
	assign remain = end_words - wr_off;
	assign avail  = (remain > BURST) ? BURST : remain;
	assign can_go = pend_end ? (avail != '0 && fifo_cnt >= avail && !fifo_empty)
	                         : (fifo_cnt >= BURST);

	assign fifo_rd    = in_beats && (beat < bst_len); // short tail burst leaves beats idle
	assign mem.wvalid = fifo_rd;
	assign mem.wdata  = fifo_dout;
	assign mem.addr   = {wr_ptr, wr_off[`FB_FRAME_WORDS_WIDTH-1:0]};

	always_ff @(posedge clk_frame_buf) begin
		if (i_rst) begin
			bst_state <= WR_IDLE;
			mem.req   <= 1'b0;
			in_beats  <= 1'b0;
			beat      <= '0;
			bst_len   <= '0;
			commit    <= 1'b0;
			wr_off    <= '0;
			wr_ptr    <= '0;
			base_ptr  <= '0;
			occ       <= '0;
		end else begin
			commit <= 1'b0;
			case (bst_state)
				WR_BURST: begin
					if (mem.ack) begin
						mem.req  <= 1'b0;
						in_beats <= 1'b1;
						beat     <= '0;
					end
					if (in_beats) begin
						beat <= beat + 1'b1;
						if (mem.last) begin
							in_beats  <= 1'b0;
							bst_state <= WR_IDLE;
							wr_off    <= wr_off + bst_len;
							commit    <= pend_end && (wr_off + bst_len == end_words);
						end
					end
				end
				default: begin
					if (can_go && !commit) begin // offset settles after commit
						mem.req   <= 1'b1;
						bst_len   <= pend_end ? avail : BURST;
						bst_state <= WR_BURST;
					end else if (pend_end && remain == '0 && !commit) begin
						commit <= 1'b1; // fval fell after the final burst
					end
				end
			endcase
			if (commit) begin // one cycle after the frame's last beat
				wr_off <= '0;
				wr_ptr <= ptr_next(wr_ptr, i_frame_depth);
			end
			if (i_release) base_ptr <= ptr_next(base_ptr, i_frame_depth);
			occ <= occ + slot_cnt_t'(commit) - slot_cnt_t'(i_release);
		end
	end

	assign o_frame_ready = (occ != '0);
	assign o_base_ptr    = base_ptr;

endmodule

// File: design/frame_buffer.sv
/* single clock frame buffer over on-chip memory; depth and size are sampled live,
   change them only while no frame is stored */
`timescale 1ns/1ps

module frame_buffer
	import fb_types_pkg::*;
(
	input  logic         clk_frame_buf,
	input  logic         i_rst,
	// video in
	input  logic         i_fval,
	input  logic         i_dval,
	input  pixel_t       i_image_din,
	output logic         o_front_fifo_full,
	// video out
	input  logic         i_buf_rd,
	output logic         o_buf_empty,
	output logic         o_buf_pe,      // fewer than one burst held
	output out_word_t    o_image_dout,
	// config
	input  frame_ptr_t   i_frame_depth, // slots minus one
	input  frame_words_t i_frame_size
);
	logic       frame_ready, release_pulse;
	frame_ptr_t base_ptr;

	fb_mem_port_if wr_port ();
	fb_mem_port_if rd_port ();

	fb_wr_logic u_wr_logic (
		.clk_frame_buf     (clk_frame_buf),
		.i_rst             (i_rst),
		.i_fval            (i_fval),
		.i_dval            (i_dval),
		.i_image_din       (i_image_din),
		.i_frame_depth     (i_frame_depth),
		.i_release         (release_pulse),
		.o_front_fifo_full (o_front_fifo_full),
		.o_frame_ready     (frame_ready),
		.o_base_ptr        (base_ptr),
		.mem               (wr_port.requester)
	);

	fb_rd_logic u_rd_logic (
		.clk_frame_buf (clk_frame_buf),
		.i_rst         (i_rst),
		.i_frame_ready (frame_ready),
		.i_base_ptr    (base_ptr),
		.i_frame_size  (i_frame_size),
		.i_frame_depth (i_frame_depth),
		.i_buf_rd      (i_buf_rd),
		.o_release     (release_pulse),
		.o_buf_empty   (o_buf_empty),
		.o_buf_pe      (o_buf_pe),
		.o_image_dout  (o_image_dout),
		.mem           (rd_port.requester)
	);

	fb_mem_ctrl u_mem_ctrl (
		.clk_frame_buf (clk_frame_buf),
		.i_rst         (i_rst),
		.wr_port       (wr_port.arbiter),
		.rd_port       (rd_port.arbiter)
	);

endmodule

// File: verif/fb_trace.txt
# S depth size : depth is slots minus one, size in words (decimal)
# W base | G base | E base : write, gappy write, drain; base in hex, pixel i = base+i
# one slot ring
S 0 32
W 00001000
# slot still busy when this frame starts, it is dropped
W 00002000
E 00001000
W 00003000
E 00003000
# two slots, frames larger than the output fifo
S 1 96
W 00010000
W 00020000
E 00010000
E 00020000
# gaps on dval
S 1 48
G 00030000
E 00030000
G 00040000
E 00040000
# four slots without reading, fifth frame dropped
S 3 80
W 00100000
W 00200000
W 00300000
W 00400000
W 00500000
E 00100000
E 00200000
E 00300000
E 00400000

// File: verif/tb_clk_gen.sv
/* free running testbench clock, starts low */
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter real PERIOD = 4.0   // ns
) (
	output logic o_clk
);
	initial begin
		o_clk = 1'b0;
	end

	always #(PERIOD / 2.0) o_clk = ~o_clk; // half period per phase

endmodule

// File: verif/tb_frame_buffer.sv
/* trace driven testbench, reads verif/fb_trace.txt relative to the project root
   inputs move 1 ns after the rising edge, first mismatch or timeout ends the run */
`timescale 1ns/1ps
`include "fb_config.svh"

module tb_frame_buffer
	import fb_types_pkg::*;
();
	localparam int TIMEOUT = 2000;   // cycles allowed per wait
	localparam int QUIET   = 400;    // idle window after the trace

	logic         clk_frame_buf;
	logic         i_rst;
	logic         i_fval;
	logic         i_dval;
	logic         i_buf_rd;
	pixel_t       i_image_din;
	frame_ptr_t   i_frame_depth;
	frame_words_t i_frame_size;
	logic         o_front_fifo_full;
	logic         o_buf_empty;
	logic         o_buf_pe;
	out_word_t    o_image_dout;

	integer seed;     // gap pattern of i_dval
	integer drained;  // frames checked

	tb_clk_gen #(.PERIOD(4.0)) u_clk_gen (.o_clk(clk_frame_buf));

	frame_buffer i_frame_buffer (
		.clk_frame_buf     (clk_frame_buf),
		.i_rst             (i_rst),
		.i_fval            (i_fval),
		.i_dval            (i_dval),
		.i_image_din       (i_image_din),
		.o_front_fifo_full (o_front_fifo_full),
		.i_buf_rd          (i_buf_rd),
		.o_buf_empty       (o_buf_empty),
		.o_buf_pe          (o_buf_pe),
		.o_image_dout      (o_image_dout),
		.i_frame_depth     (i_frame_depth),
		.i_frame_size      (i_frame_size)
	);

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	task automatic step_clk();
		@(posedge clk_frame_buf);
		#1; // drive point
	endtask

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Simulation FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_val(input string name, input logic [63:0] exp_val,
	                         input logic [63:0] act_val);
		if (act_val !== exp_val) begin
			$display("[FAIL] %s: expected 0x%0h, got 0x%0h", name, exp_val, act_val);
			$display("Simulation FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// one frame of base+i, gappy picks dval at random
	task automatic write_frame(input pixel_t base, input logic gappy);
		int          i;
		int          stall;
		logic        dv;
		logic [31:0] rnd;
		i = 0;
		stall = 0;
		i_fval = 1'b1;
		while (i < int'(i_frame_size)) begin
			if (gappy) begin
				rnd = $random(seed);
				dv = rnd[0];
			end else begin
				dv = 1'b1;
			end
			if (o_front_fifo_full)
				dv = 1'b0; // back pressure
			i_dval = dv;
			i_image_din = base + pixel_t'(i);
			step_clk();
			if (dv) begin
				i++;
				stall = 0;
			end else begin
				stall++;
				if (stall > TIMEOUT)
					fail_run("timeout: front FIFO accepted no pixel for too long");
			end
		end
		i_fval = 1'b0;
		i_dval = 1'b0;
		repeat (4) step_clk(); // blanking
	endtask

	// pop one frame, data and start flag per word
	task automatic drain_frame(input pixel_t base);
		int i;
		int wait_cnt;
		for (i = 0; i < int'(i_frame_size); i++) begin
			wait_cnt = 0;
			while (o_buf_empty) begin
				i_buf_rd = 1'b0;
				step_clk();
				wait_cnt++;
				if (wait_cnt > TIMEOUT)
					fail_run("timeout: output FIFO stayed empty in the middle of a frame");
			end
			check_val("o_image_dout[data]", base + pixel_t'(i),
			          o_image_dout[`FB_DATA_WIDTH-1:0]);
			check_val("o_image_dout[flag]", i == 0, o_image_dout[`FB_DATA_WIDTH]);
			i_buf_rd = 1'b1; // fwft, pop on this edge
			step_clk();
		end
		i_buf_rd = 1'b0;
		drained++;
	endtask

	// nothing may come out once all stored frames are gone
	task automatic check_quiet();
		repeat (QUIET) begin
			step_clk();
			check_val("o_buf_empty", 1, o_buf_empty);
			check_val("o_buf_pe", 1, o_buf_pe); // empty is below one burst
		end
	endtask

	// ----------------------------------------
	// trace
	// ----------------------------------------
	task automatic run_trace();
		integer             fd;
		integer             code;
		integer             a;
		integer             b;
		logic [7:0]         cmd;
		logic [8*128-1:0]   rest;
		fd = $fopen("verif/fb_trace.txt", "r");
		if (fd == 0) begin
			fail_run("could not open the trace file verif/fb_trace.txt");
		end else begin
			code = $fscanf(fd, " %c", cmd);
			while (code == 1) begin
				case (cmd)
					"#": code = $fgets(rest, fd); // comment line
					"S": begin
						code = $fscanf(fd, "%d %d", a, b);
						if (code != 2)
							fail_run("trace line S is missing depth or size");
						i_frame_depth = frame_ptr_t'(a);
						i_frame_size  = frame_words_t'(b);
						step_clk();
					end
					"W", "G", "E": begin
						code = $fscanf(fd, "%h", a);
						if (code != 1)
							fail_run("trace line is missing its base value");
						if (cmd == "E")
							drain_frame(pixel_t'(a));
						else
							write_frame(pixel_t'(a), cmd == "G");
					end
					default: fail_run("unknown command letter in the trace file");
				endcase
				code = $fscanf(fd, " %c", cmd);
			end
			$fclose(fd);
		end
	endtask

	initial begin
		seed          = 32'hb41e022d;
		drained       = 0;
		i_rst         = 1'b1;
		i_fval        = 1'b0;
		i_dval        = 1'b0;
		i_buf_rd      = 1'b0;
		i_image_din   = '0;
		i_frame_depth = '0;
		i_frame_size  = frame_words_t'(`FB_BURST_LEN);
		repeat (10) @(posedge clk_frame_buf);
		#1;
		i_rst = 1'b0;

		// idle state straight out of reset
		check_val("o_buf_empty", 1, o_buf_empty);
		check_val("o_buf_pe", 1, o_buf_pe);
		check_val("o_front_fifo_full", 0, o_front_fifo_full);

		run_trace();
		check_quiet(); // dropped frame must never show up

		if (drained > 0) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			$display("no frame was checked");
			$display("Simulation FAILED");
			$fatal(1, "run ended with errors");
		end
	end

endmodule

// File: vlog.f
+incdir+design
design/fb_types_pkg.sv
design/fb_ctrl_pkg.sv
design/fb_mem_port_if.sv
design/fb_sync_fifo.sv
design/fb_wr_logic.sv
design/fb_rd_logic.sv
design/fb_mem_ctrl.sv
design/frame_buffer.sv
verif/tb_clk_gen.sv
verif/tb_frame_buffer.sv
